// File: fetch_macros.svh
/*
 * Fetch subsystem configuration defines
 * Reset address, in-flight limit, memory depth and response queue depth
 */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// ------------------------------------------------
// Fetch unit
// ------------------------------------------------

// First address fetched out of reset
`define FETCH_RST_ADDR 32'h200

// Max outstanding requests, squashed ones included
`define FETCH_MAX_IN_FLIGHT 4

// ------------------------------------------------
// Instruction memory
// ------------------------------------------------

// Depth in words, index from addr[9:2] so fetch wraps every 1 KiB
`define IMEM_WORDS 256

// Response queue entries, at least the read pipeline depth of 2
`define IMEM_QUEUE_DEPTH 4

`endif

// File: mem_pkg.sv
/*
 * Memory message types
 * Address and data vectors, operation enum, request and response structs
 */
package mem_pkg;

  // ------------------------------------------------
  // Vectors
  // ------------------------------------------------

  // Byte address
  typedef logic [31:0] addr_t;

  // Data word
  typedef logic [31:0] word_t;

  // Access kind
  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_op_e;

  // ------------------------------------------------
  // Messages
  // ------------------------------------------------

  // Request toward memory
  typedef struct packed {
    mem_op_e    op;
    logic       opaque;
    addr_t      addr;
    logic [3:0] len;
    word_t      data;
  } mem_req_t;

  // Response from memory, opaque echoed back from the request
  typedef struct packed {
    mem_op_e    op;
    logic       opaque;
    addr_t      addr;
    logic [3:0] len;
    word_t      data;
  } mem_resp_t;

endpackage

// File: fetch_pkg.sv
/*
 * Fetch-side types
 * Epoch and sequence number vectors, decode packet and redirect structs
 */
package fetch_pkg;

  // ------------------------------------------------
  // Vectors
  // ------------------------------------------------

  // Fetch epoch, flips on every redirect
  typedef logic epoch_t;

  // Count of instructions handed to decode, wraps at 256
  typedef logic [7:0] seq_num_t;

  // ------------------------------------------------
  // Messages
  // ------------------------------------------------

  // Instruction packet toward decode
  typedef struct packed {
    mem_pkg::addr_t pc;
    mem_pkg::word_t inst;
    seq_num_t       seq_num;
  } fetch_pkt_t;

  // Redirect from a later stage
  typedef struct packed {
    mem_pkg::addr_t pc;
  } redirect_t;

endpackage

// File: mem_resp_fifo.sv
/*
 * Fall-through response FIFO
 * Circular buffer, bypasses the input when empty
 */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module mem_resp_fifo (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    in_val,
  input  mem_pkg::mem_resp_t                      in_msg,
  output logic                                    out_val,
  input  logic                                    out_rdy,
  output mem_pkg::mem_resp_t                      out_msg,
  output logic [$clog2(`IMEM_QUEUE_DEPTH + 1)-1:0] count
);

  localparam int unsigned DEPTH = `IMEM_QUEUE_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  mem_pkg::mem_resp_t entries [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic               empty;
  logic               push;
  logic               pop;

  // Pointer step with wrap at DEPTH
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Empty queue with a ready consumer hands the input straight out
  always_comb begin
    empty   = (count == '0);
    out_val = in_val | !empty;
    out_msg = empty ? in_msg : entries[rd_ptr];
    push    = in_val & !(empty & out_rdy);
    pop     = out_rdy & !empty;
  end

  // ------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= in_msg;
    end
  end

endmodule

// File: inst_mem.sv
/*
 * Instruction memory
 * Word array with load port, two-stage read pipeline, credit-based
 * request ready and a fall-through response queue
 */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module inst_mem (
  input  logic               clk,
  input  logic               rst,

  // Program load port
  input  logic               load_en,
  input  mem_pkg::addr_t     load_addr,
  input  mem_pkg::word_t     load_data,

  // Request channel
  input  logic               mem_req_val,
  output logic               mem_req_rdy,
  input  mem_pkg::mem_req_t  mem_req_msg,

  // Response channel
  output logic               mem_resp_val,
  input  logic               mem_resp_rdy,
  output mem_pkg::mem_resp_t mem_resp_msg
);

  localparam int unsigned WORDS = `IMEM_WORDS;
  localparam int unsigned IDX_W = $clog2(WORDS);
  localparam int unsigned DEPTH = `IMEM_QUEUE_DEPTH;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  mem_pkg::word_t     words [WORDS];

  logic               req_xfer;
  logic               s1_val;
  mem_pkg::mem_req_t  s1_req;
  logic               s2_val;
  mem_pkg::mem_resp_t s2_resp;
  logic [CNT_W-1:0]   q_count;
  logic [CNT_W:0]     used;

  // ------------------------------------------------
  // Word array
  // ------------------------------------------------

  // Load port stays live through reset
  always_ff @(posedge clk) begin
    if (load_en) begin
      words[load_addr[IDX_W+1:2]] <= load_data;
    end
  end

  // ------------------------------------------------
  // Read pipeline
  // ------------------------------------------------

  always_comb begin
    req_xfer = mem_req_val & mem_req_rdy;
  end

  // Valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
    end else begin
      s1_val <= req_xfer;
      s2_val <= s1_val;
    end
  end

  // Stage 1 latches the request, stage 2 adds the array word
  always_ff @(posedge clk) begin
    if (req_xfer) begin
      s1_req <= mem_req_msg;
    end
    if (s1_val) begin
      s2_resp.op     <= s1_req.op;
      s2_resp.opaque <= s1_req.opaque;
      s2_resp.addr   <= s1_req.addr;
      s2_resp.len    <= s1_req.len;
      s2_resp.data   <= words[s1_req.addr[IDX_W+1:2]];
    end
  end

  // ------------------------------------------------
  // Credits
  // ------------------------------------------------

  // Every response in the pipeline already owns a queue slot
  always_comb begin
    used        = {1'b0, q_count} + (CNT_W+1)'(s1_val) + (CNT_W+1)'(s2_val);
    mem_req_rdy = (used < (CNT_W+1)'(DEPTH));
  end

  mem_resp_fifo mem_resp_fifo_inst (
    .clk     (clk),
    .rst     (rst),
    .in_val  (s2_val),
    .in_msg  (s2_resp),
    .out_val (mem_resp_val),
    .out_rdy (mem_resp_rdy),
    .out_msg (mem_resp_msg),
    .count   (q_count)
  );

endmodule

// File: fetch_unit.sv
/*
 * Fetch unit
 * Sequential address generation with an in-flight limit, epoch tagging,
 * stale-response squashing and sequence numbering toward decode
 */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_unit (
  input  logic                  clk,
  input  logic                  rst,

  // Memory request channel
  output logic                  mem_req_val,
  input  logic                  mem_req_rdy,
  output mem_pkg::mem_req_t     mem_req_msg,

  // Memory response channel
  input  logic                  mem_resp_val,
  output logic                  mem_resp_rdy,
  input  mem_pkg::mem_resp_t    mem_resp_msg,

  // Redirect strobe
  input  logic                  redirect_val,
  input  fetch_pkg::redirect_t  redirect_msg,

  // Decode channel
  output logic                  dec_val,
  input  logic                  dec_rdy,
  output fetch_pkg::fetch_pkt_t dec_pkt
);

  // Counter must be able to hold the limit itself
  localparam int unsigned MAX_IN_FLIGHT = `FETCH_MAX_IN_FLIGHT;
  localparam int unsigned CNT_W         = $clog2(MAX_IN_FLIGHT + 1);

  // Transfer strobes
  logic req_xfer;
  logic resp_xfer;
  logic dec_xfer;

  // Request side state
  logic [CNT_W-1:0]  in_flight;
  logic [CNT_W-1:0]  in_flight_next;
  mem_pkg::addr_t    curr_addr;
  fetch_pkg::epoch_t epoch;

  // Response side state
  logic                resp_fresh;
  fetch_pkg::seq_num_t seq_num;

  always_comb begin
    req_xfer  = mem_req_val & mem_req_rdy;
    resp_xfer = mem_resp_val & mem_resp_rdy;
    dec_xfer  = dec_val & dec_rdy;
  end

  // ------------------------------------------------
  // Request path
  // ------------------------------------------------

  // Outstanding requests, dropped responses still count until consumed
  always_comb begin
    in_flight_next = in_flight;
    if (req_xfer && !resp_xfer) begin
      in_flight_next = in_flight + 1'b1;
    end else if (resp_xfer && !req_xfer) begin
      in_flight_next = in_flight - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight_next;
    end
  end

  // Redirect wins over the sequential advance
  always_ff @(posedge clk) begin
    if (rst) begin
      curr_addr <= `FETCH_RST_ADDR;
      epoch     <= 1'b0;
    end else if (redirect_val) begin
      curr_addr <= redirect_msg.pc;
      epoch     <= ~epoch;
    end else if (req_xfer) begin
      curr_addr <= curr_addr + 32'd4;
    end
  end

  // Word reads only, epoch rides in the opaque field
  always_comb begin
    mem_req_val        = (in_flight < CNT_W'(MAX_IN_FLIGHT));
    mem_req_msg.op     = mem_pkg::MEM_READ;
    mem_req_msg.opaque = epoch;
    mem_req_msg.addr   = curr_addr;
    mem_req_msg.len    = 4'd0;
    mem_req_msg.data   = '0;
  end

  // ------------------------------------------------
  // Response path
  // ------------------------------------------------

  // Judged against the epoch register, so a same-cycle redirect
  // does not affect the response seen this cycle
  always_comb begin
    resp_fresh = (mem_resp_msg.opaque == epoch);
  end

  // Fresh responses pass straight through to decode
  // Stale ones are drained without showing up on dec_val
  always_comb begin
    dec_val      = mem_resp_val & resp_fresh;
    mem_resp_rdy = resp_fresh ? dec_rdy : 1'b1;
  end

  // Delivered instruction count, redirects leave it alone
  always_ff @(posedge clk) begin
    if (rst) begin
      seq_num <= '0;
    end else if (dec_xfer) begin
      seq_num <= seq_num + 1'b1;
    end
  end

  // Packet fields come straight from the response
  always_comb begin
    dec_pkt.pc      = mem_resp_msg.addr;
    dec_pkt.inst    = mem_resp_msg.data;
    dec_pkt.seq_num = seq_num;
  end

endmodule

// File: fetch_top.sv
/*
 * Fetch subsystem top level
 * Fetch unit wired to the instruction memory
 */
`timescale 1ns/1ps

module fetch_top (
  input  logic                  clk,
  input  logic                  rst,

  // Program load port
  input  logic                  load_en,
  input  mem_pkg::addr_t        load_addr,
  input  mem_pkg::word_t        load_data,

  // Redirect strobe
  input  logic                  redirect_val,
  input  fetch_pkg::redirect_t  redirect_msg,

  // Decode channel
  output logic                  dec_val,
  input  logic                  dec_rdy,
  output fetch_pkg::fetch_pkt_t dec_pkt
);

  // ------------------------------------------------
  // Memory link
  // ------------------------------------------------

  logic               mem_req_val;
  logic               mem_req_rdy;
  mem_pkg::mem_req_t  mem_req_msg;
  logic               mem_resp_val;
  logic               mem_resp_rdy;
  mem_pkg::mem_resp_t mem_resp_msg;

  fetch_unit fetch_unit_inst (
    .clk          (clk),
    .rst          (rst),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_req_msg  (mem_req_msg),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .mem_resp_msg (mem_resp_msg),
    .redirect_val (redirect_val),
    .redirect_msg (redirect_msg),
    .dec_val      (dec_val),
    .dec_rdy      (dec_rdy),
    .dec_pkt      (dec_pkt)
  );

  inst_mem inst_mem_inst (
    .clk          (clk),
    .rst          (rst),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_req_msg  (mem_req_msg),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .mem_resp_msg (mem_resp_msg)
  );

endmodule

// File: tb_fetch_top.sv
/*
 * Testbench for the fetch subsystem
 * Random program load, redirects and decode back-pressure, checked
 * against a shadow memory with a pc and sequence number model
 */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module tb_fetch_top;

  // Tests take about 3k cycles together, the limit leaves a wide margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam logic [31:0] SEED = 32'hddcf_88ed;

  logic                  clk;
  logic                  rst;
  logic                  load_en;
  mem_pkg::addr_t        load_addr;
  mem_pkg::word_t        load_data;
  logic                  redirect_val;
  fetch_pkg::redirect_t  redirect_msg;
  logic                  dec_val;
  logic                  dec_rdy;
  fetch_pkg::fetch_pkt_t dec_pkt;

  // Reference model
  mem_pkg::word_t        shadow [`IMEM_WORDS];
  mem_pkg::addr_t        exp_pc;
  fetch_pkg::seq_num_t   exp_seq;
  logic                  active;

  // Monitor history from the previous cycle
  logic                  hold_prev;
  logic                  redir_prev;
  fetch_pkg::fetch_pkt_t held_pkt;

  int                    rx_count;
  int                    cycle_count;
  string                 cur_test;
  int                    cur_checks;
  int                    cur_errors;
  int                    tests_run;
  int                    tests_failed;
  int                    total_checks;
  int                    total_errors;

  fetch_top fetch_top_inst (
    .clk          (clk),
    .rst          (rst),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .redirect_val (redirect_val),
    .redirect_msg (redirect_msg),
    .dec_val      (dec_val),
    .dec_rdy      (dec_rdy),
    .dec_pkt      (dec_pkt)
  );

  always #5 clk = ~clk;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  function automatic mem_pkg::addr_t random_target();
    random_target = $urandom & 32'hffff_fffc;
  endfunction

  // One cycle strobe
  task automatic apply_redirect(input mem_pkg::addr_t target);
    redirect_val    = 1'b1;
    redirect_msg.pc = target;
    step();
    redirect_val    = 1'b0;
  endtask

  task automatic wait_packets(input int n);
    int target;
    target = rx_count + n;
    while (rx_count < target) begin
      step();
    end
  endtask

  // Random words to every location, reset dropped partway through
  task automatic load_program();
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      step();
      if (i == 9) begin
        rst = 1'b0;
      end
      load_en   = 1'b1;
      load_addr = 32'(i) << 2;
      load_data = $urandom;
      shadow[i] = load_data;
    end
    step();
    load_en = 1'b0;
  endtask

  task automatic check_packet();
    mem_pkg::word_t exp_inst;
    exp_inst   = shadow[exp_pc[9:2]];
    cur_checks = cur_checks + 3;
    if (dec_pkt.pc !== exp_pc) begin
      cur_errors++;
      $display("[ERROR] %s: pc expected %h actual %h", cur_test, exp_pc, dec_pkt.pc);
    end
    if (dec_pkt.inst !== exp_inst) begin
      cur_errors++;
      $display("[ERROR] %s: inst expected %h actual %h", cur_test, exp_inst, dec_pkt.inst);
    end
    if (dec_pkt.seq_num !== exp_seq) begin
      cur_errors++;
      $display("[ERROR] %s: seq_num expected %0d actual %0d", cur_test, exp_seq,
               dec_pkt.seq_num);
    end
  endtask

  task automatic end_test();
    if (cur_checks == 0) begin
      cur_errors++;
      $display("%s: no packets were checked", cur_test);
    end
    tests_run++;
    total_checks = total_checks + cur_checks;
    total_errors = total_errors + cur_errors;
    if (cur_errors != 0) begin
      tests_failed++;
      $display("[FAIL] %s: %0d checks, %0d errors", cur_test, cur_checks, cur_errors);
    end else begin
      $display("[ok]   %s: %0d checks, %0d errors", cur_test, cur_checks, cur_errors);
    end
    cur_checks = 0;
    cur_errors = 0;
  endtask

  // --------------------------------------------------
  // Monitor and model
  // --------------------------------------------------

  // Falling edge sees settled inputs and outputs for the coming edge
  always @(negedge clk) begin
    if (!rst) begin
      // Stalled packet must hold unless a redirect squashed it
      if (active && hold_prev && !redir_prev) begin
        cur_checks++;
        if (!dec_val) begin
          cur_errors++;
          $display("%s: dec_val dropped while decode was stalled", cur_test);
        end else if (dec_pkt !== held_pkt) begin
          cur_errors++;
          $display("[ERROR] %s: held dec_pkt expected %h actual %h", cur_test,
                   held_pkt, dec_pkt);
        end
      end
      // Transfer in a redirect cycle still belongs to the old stream
      if (dec_val && dec_rdy) begin
        if (active) begin
          check_packet();
        end
        exp_pc  = exp_pc + 32'd4;
        exp_seq = exp_seq + 1'b1;
        rx_count++;
      end
      hold_prev  = dec_val && !dec_rdy;
      held_pkt   = dec_pkt;
      redir_prev = redirect_val;
      if (redirect_val) begin
        active = 1'b1;
        exp_pc = redirect_msg.pc;
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles in test %s", cycle_count, cur_test);
      $display("Simulation failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin : main_flow
    int seed_val;
    int gap;
    clk          = 1'b0;
    rst          = 1'b1;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    redirect_val = 1'b0;
    redirect_msg = '0;
    dec_rdy      = 1'b1;
    exp_pc       = '0;
    exp_seq      = '0;
    active       = 1'b0;
    hold_prev    = 1'b0;
    redir_prev   = 1'b0;
    held_pkt     = '0;
    rx_count     = 0;
    cycle_count  = 0;
    cur_checks   = 0;
    cur_errors   = 0;
    tests_run    = 0;
    tests_failed = 0;
    total_checks = 0;
    total_errors = 0;
    seed_val     = $urandom(SEED);

    // Enough packets to cross the 1 KiB wrap from 0x200
    cur_test = "load_and_sequential";
    load_program();
    apply_redirect(`FETCH_RST_ADDR);
    wait_packets(300);
    end_test();

    // Count runs past 255 and survives the redirect
    cur_test = "sequence_numbering";
    apply_redirect(random_target());
    wait_packets(280);
    end_test();

    // Gap of 20 or more lets the 1-bit epoch drain old responses
    cur_test = "redirect_squash";
    for (int r = 0; r < 30; r++) begin
      gap = 20 + ($urandom % 20);
      repeat (gap) step();
      apply_redirect(random_target());
    end
    wait_packets(20);
    end_test();

    cur_test = "decode_backpressure";
    for (int c = 0; c < 600; c++) begin
      dec_rdy = (($urandom % 2) == 1);
      if ((c % 80) == 40) begin
        redirect_val    = 1'b1;
        redirect_msg.pc = random_target();
      end else begin
        redirect_val = 1'b0;
      end
      step();
    end
    redirect_val = 1'b0;
    dec_rdy      = 1'b1;
    wait_packets(10);
    end_test();

    // Queue and in-flight limit must absorb the stall
    cur_test = "long_stall";
    dec_rdy  = 1'b0;
    repeat (50) step();
    cur_checks++;
    if (!dec_val) begin
      cur_errors++;
      $display("%s: no packet waiting at the end of the stall", cur_test);
    end
    dec_rdy = 1'b1;
    wait_packets(40);
    end_test();

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d", tests_run,
             tests_failed, total_checks, total_errors);
    if (tests_failed == 0 && total_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+.
mem_pkg.sv
fetch_pkg.sv
mem_resp_fifo.sv
inst_mem.sv
fetch_unit.sv
fetch_top.sv
tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_subsystem

sources:
  - include_dirs:
      - .
    files:
      - mem_pkg.sv
      - fetch_pkg.sv
      - mem_resp_fifo.sv
      - inst_mem.sv
      - fetch_unit.sv
      - fetch_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fetch_top.sv
